//--- bench/tb_zpu_ctrl.sv
// Testbench for the control-plane subsystem: random bus traffic and SFP pin changes
// checked against a register and flag model, then the processor restart pulse
`timescale 1ns/1ns
`default_nettype none

module tb_zpu_ctrl;
   import zpu_ctrl_pkg::*;

   localparam int SB_ADDRW = 8;
   localparam int ACK_TMO  = 16;                  // Cycles before an access counts as lost
   localparam int N_OPS    = 400;
   localparam int LOW_W    = AW - REGION_W;
   localparam logic [AW-1:0] WIN_BASE = {SETTINGS_BASE, {LOW_W{1'b0}}};
   // Product id in the top byte, major in the middle, minor in the lowest byte
   localparam logic [DW-1:0] COMPAT_WORD = (DW'(PRODUCT_ID) << 24)
                                         | (DW'(COMPAT_MAJOR) << 8)
                                         | DW'(COMPAT_MINOR);

   logic                clk = 1'b0;
   logic                rst;
   logic                bus_stb;
   logic                bus_we;
   logic [AW-1:0]       bus_adr;
   logic [DW-1:0]       bus_wdat;
   logic [DW-1:0]       bus_rdat;
   logic                bus_ack;
   logic [1:0]          sfp0_rs_drv;
   logic [1:0]          sfp1_rs_drv;
   logic [SW_RST_W-1:0] sw_rst;
   logic [LEDS_W-1:0]   leds;
   logic                cpu_rst;

   integer seed;

   //---------------------------------------------------------------------
   // Reference model
   //---------------------------------------------------------------------
   logic [SW_RST_W-1:0] m_sw_rst;
   logic [LEDS_W-1:0]   m_leds;
   logic [1:0]          m_drv [2];               // RS drive enables per port
   logic [SFP_PINS-1:0] m_pins [2];              // Also the pin stimulus
   logic [SFP_PINS-1:0] m_flags [2];             // Changes since last status read
   logic [31:0]         m_last_cnt;
   int                  wr_regs [4] = '{SR_SW_RST, SR_LEDS, SR_SFP_CTRL0, SR_SFP_CTRL1};

   int                  cycle = 0;               // Posedge count
   int                  ack_cycle = 0;
   int                  pulse_cycle = 0;
   int                  pulse_cnt = 0;           // cpu_rst_o high cycles after reset
   logic                mon_en = 1'b0;

   zpu_ctrl_subsystem #(.SB_ADDRW(SB_ADDRW)) u_zpu_ctrl_subsystem (
      .clk(clk), .rst(rst),
      .bus_stb_i(bus_stb), .bus_we_i(bus_we), .bus_adr_i(bus_adr), .bus_dat_i(bus_wdat),
      .bus_dat_o(bus_rdat), .bus_ack_o(bus_ack),
      .sfp0_pins_i(m_pins[0]), .sfp1_pins_i(m_pins[1]),
      .sfp0_rs_drv_o(sfp0_rs_drv), .sfp1_rs_drv_o(sfp1_rs_drv),
      .sw_rst_o(sw_rst), .leds_o(leds), .cpu_rst_o(cpu_rst)
   );

   always #4 clk = ~clk;                         // 8 ns period

   always @(posedge clk) cycle <= cycle + 1;

   // Sampled mid-cycle, where DUT outputs are settled
   always @(negedge clk) begin
      if (mon_en && cpu_rst) begin
         pulse_cnt   <= pulse_cnt + 1;
         pulse_cycle <= cycle;
      end
   end

   //---------------------------------------------------------------------
   // Helpers
   //---------------------------------------------------------------------
   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
         stop_with_error($sformatf("MISMATCH at %0t ns: %s expected 0x%08h actual 0x%08h",
                                   $time, name, exp, act));
   endtask

   task automatic check_outputs();
      check("sw_rst_o", m_sw_rst, sw_rst);
      check("leds_o", m_leds, leds);
      check("sfp0_rs_drv_o", m_drv[0], sfp0_rs_drv);
      check("sfp1_rs_drv_o", m_drv[1], sfp1_rs_drv);
   endtask

   function automatic logic [AW-1:0] win_adr(input int word);
      return WIN_BASE | AW'(word << 2);          // Word address in bits 9:2
   endfunction

   function automatic logic [AW-1:0] outside_adr();
      logic [REGION_W-1:0] nib;
      nib = REGION_W'($unsigned($random(seed)) % 15);
      if (nib >= SETTINGS_BASE)
         nib = nib + 1'b1;                       // Skip the window nibble
      return {nib, LOW_W'($random(seed))};
   endfunction

   // One strobed access, entered and left on a falling edge
   task automatic bus_access(input logic we, input logic [AW-1:0] adr,
                             input logic [DW-1:0] wdat, output logic [DW-1:0] rdat);
      int waited;
      bus_stb  = 1'b1;
      bus_we   = we;
      bus_adr  = adr;
      bus_wdat = wdat;
      waited   = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!bus_ack && waited < ACK_TMO);
      if (!bus_ack)
         stop_with_error($sformatf("Bus access to 0x%04h got no ack within %0d cycles",
                                   adr, ACK_TMO));
      check("bus_ack_o latency", 2, waited);
      rdat      = bus_rdat;
      ack_cycle = cycle;
      @(negedge clk);                            // Hold strobe through the ack edge
      check("bus_ack_o width", 0, bus_ack);
      bus_stb = 1'b0;
      bus_we  = 1'b0;
      @(negedge clk);                            // Idle gap
   endtask

   task automatic read_expect(input logic [AW-1:0] adr, input logic [DW-1:0] exp,
                              input string name);
      logic [DW-1:0] rd;
      bus_access(1'b0, adr, $random(seed), rd);
      check(name, exp, rd);
   endtask

   // Toggle random pins on both ports, settle, then read one port twice
   task automatic sfp_step();
      logic [SFP_PINS-1:0] mask;
      int                  p;
      for (p = 0; p < 2; p++) begin
         mask       = SFP_PINS'($random(seed));
         m_pins[p]  = m_pins[p] ^ mask;
         m_flags[p] = m_flags[p] | mask;
      end
      repeat (4 + $unsigned($random(seed)) % 4) @(negedge clk);
      p = $unsigned($random(seed)) % 2;
      read_expect(win_adr(RB_SFP_STATUS0 + p), DW'({m_flags[p], m_pins[p]}),
                  $sformatf("sfp%0d status", p));
      m_flags[p] = '0;                           // Cleared by the read
      read_expect(win_adr(RB_SFP_STATUS0 + p), DW'({m_flags[p], m_pins[p]}),
                  $sformatf("sfp%0d status reread", p));
   endtask

   //---------------------------------------------------------------------
   // Stimulus
   //---------------------------------------------------------------------
   initial begin
      logic [DW-1:0] rd;
      logic [DW-1:0] wdat;
      int            kind;
      int            sel;
      seed       = 27961;
      rst        = 1'b1;
      bus_stb    = 1'b0;
      bus_we     = 1'b0;
      bus_adr    = '0;
      bus_wdat   = '0;
      m_sw_rst   = '0;
      m_leds     = '0;
      m_drv[0]   = '0;
      m_drv[1]   = '0;
      m_pins[0]  = '0;
      m_pins[1]  = '0;
      m_flags[0] = '0;
      m_flags[1] = '0;
      m_last_cnt = '0;
      repeat (8) @(negedge clk);
      check("cpu_rst_o in reset", 1, cpu_rst);
      rst = 1'b0;
      @(negedge clk);
      check("cpu_rst_o after reset", 0, cpu_rst);
      check("bus_ack_o after reset", 0, bus_ack);
      check_outputs();
      mon_en = 1'b1;

      for (int op = 0; op < N_OPS; op++) begin
         kind = $unsigned($random(seed)) % 6;
         wdat = $random(seed);
         case (kind)
            0: begin                             // Control register write
               sel = $unsigned($random(seed)) % 4;
               case (sel)
                  0: m_sw_rst = wdat[SW_RST_W-1:0];
                  1: m_leds   = wdat[LEDS_W-1:0];
                  2: m_drv[0] = wdat[1:0];
                  default: m_drv[1] = wdat[1:0];
               endcase
               bus_access(1'b1, win_adr(wr_regs[sel]), wdat, rd);
               check_outputs();
            end
            1: read_expect(win_adr(RB_COMPAT), COMPAT_WORD, "compat word");
            2: begin                             // Counter only moves forward
               bus_access(1'b0, win_adr(RB_COUNTER), wdat, rd);
               check($sformatf("counter 0x%08h above 0x%08h", rd, m_last_cnt), 1,
                     rd > m_last_cnt);
               m_last_cnt = rd;
            end
            3, 4: begin                          // Unmapped word, or outside the window
               bus_adr = (kind == 3) ? win_adr(5 + $unsigned($random(seed)) % 251)
                                     : outside_adr();
               if (wdat[0]) begin
                  bus_access(1'b1, bus_adr, wdat, rd);
                  check_outputs();
               end else begin
                  read_expect(bus_adr, '0, "unmapped read");
               end
            end
            default: sfp_step();
         endcase
      end

      //------------------------------------------------------------------
      // Boot restart pulse
      //------------------------------------------------------------------
      check("cpu_rst_o pulses before boot", 0, pulse_cnt);
      bus_access(1'b1, win_adr(SR_BOOT_DONE), 32'd1, rd);
      repeat (4) @(negedge clk);
      check("cpu_rst_o pulses", 1, pulse_cnt);
      check("cpu_rst_o delay after ack", 1, pulse_cycle - ack_cycle);
      bus_access(1'b1, win_adr(SR_BOOT_DONE), 32'd0, rd);
      bus_access(1'b1, win_adr(SR_BOOT_DONE), 32'd1, rd);   // Already booted
      repeat (8) @(negedge clk);
      check("cpu_rst_o pulses after rewrite", 1, pulse_cnt);
      check("cpu_rst_o", 0, cpu_rst);
      check_outputs();

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
design/zpu_ctrl_pkg.sv
design/sys_bus_decode.sv
design/settings_slave.sv
design/ctrl_regs.sv
design/sfp_monitor.sv
design/readback_mux.sv
design/zpu_ctrl_subsystem.sv
bench/tb_zpu_ctrl.sv

//--- design/ctrl_regs.sv
// Settings-bus control registers and the processor boot sequencer
// Registers load the low bits of set_data_i one cycle after a matching strobe
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs #(
   parameter int SB_ADDRW = 8
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              set_stb_i,
   input  logic [SB_ADDRW-1:0]               set_addr_i,
   input  logic [zpu_ctrl_pkg::DW-1:0]       set_data_i,
   output logic [zpu_ctrl_pkg::SW_RST_W-1:0] sw_rst_o,
   output logic [zpu_ctrl_pkg::LEDS_W-1:0]   leds_o,
   output logic [1:0]                        sfp0_rs_drv_o,
   output logic [1:0]                        sfp1_rs_drv_o,
   output logic                              cpu_rst_o
);
   import zpu_ctrl_pkg::*;

   localparam logic B_WAIT   = 1'b0;            // Firmware still booting
   localparam logic B_BOOTED = 1'b1;            // Terminal until system reset

   logic boot_done;
   logic boot_state;

   //------------------------------------------------------------------------
   // Address-matched registers
   //------------------------------------------------------------------------
   // sw_rst bits: [0] PHY, [1] radio domain, [3:2] spare
   always_ff @(posedge clk) begin
      if (rst) begin
         sw_rst_o      <= '0;
         boot_done     <= 1'b0;
         leds_o        <= '0;
         sfp0_rs_drv_o <= 2'b00;
         sfp1_rs_drv_o <= 2'b00;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SB_ADDRW'(SR_SW_RST):    sw_rst_o      <= set_data_i[SW_RST_W-1:0];
            SB_ADDRW'(SR_BOOT_DONE): boot_done     <= set_data_i[0];
            SB_ADDRW'(SR_LEDS):      leds_o        <= set_data_i[LEDS_W-1:0];
            SB_ADDRW'(SR_SFP_CTRL0): sfp0_rs_drv_o <= set_data_i[1:0];
            SB_ADDRW'(SR_SFP_CTRL1): sfp1_rs_drv_o <= set_data_i[1:0];
            default: ;                          // Unmapped, ignore
         endcase
      end
   end

   //------------------------------------------------------------------------
   // Boot sequencer
   //------------------------------------------------------------------------
   // Processor held in reset with the system, released right after,
   // then kicked once when firmware reports boot done
   always_ff @(posedge clk) begin
      if (rst) begin
         boot_state <= B_WAIT;
         cpu_rst_o  <= 1'b1;
      end else begin
         case (boot_state)
            B_WAIT: begin
               cpu_rst_o <= 1'b0;
               if (boot_done) begin
                  boot_state <= B_BOOTED;
                  cpu_rst_o  <= 1'b1;           // One-cycle restart pulse
               end
            end
            default: cpu_rst_o <= 1'b0;         // Stay booted
         endcase
      end
   end

   // Processor reset is never held for two cycles outside system reset
   a_cpu_rst_pulse: assert property (
      @(posedge clk) disable iff (rst) cpu_rst_o |=> !cpu_rst_o
   );

endmodule

`default_nettype wire

//--- design/readback_mux.sv
// Readback word selection for the settings window, plus the free-running counter
// and the read-to-clear pulses for the SFP change flags
`timescale 1ns/1ns
`default_nettype none

module readback_mux #(
   parameter int SB_ADDRW = 8
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [SB_ADDRW-1:0]                 rb_addr_i,
   input  logic                                rb_rd_stb_i,
   input  logic [2*zpu_ctrl_pkg::SFP_PINS-1:0] sfp0_status_i,
   input  logic [2*zpu_ctrl_pkg::SFP_PINS-1:0] sfp1_status_i,
   output logic [zpu_ctrl_pkg::DW-1:0]         rb_data_o,
   output logic [1:0]                          sfp_clr_o
);
   import zpu_ctrl_pkg::*;

   localparam int PAD_W = DW - 2*SFP_PINS;      // Zero fill above status

   logic [31:0] counter;

   //------------------------------------------------------------------------
   // Free-running counter
   //------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst)
         counter <= 32'd0;
      else
         counter <= counter + 32'd1;            // Wraps
   end

   //------------------------------------------------------------------------
   // Word select
   //------------------------------------------------------------------------
   always_comb begin
      case (rb_addr_i)
         SB_ADDRW'(RB_COMPAT):
            rb_data_o = {PRODUCT_ID, COMPAT_MAJOR, COMPAT_MINOR};
         SB_ADDRW'(RB_COUNTER):
            rb_data_o = counter;
         SB_ADDRW'(RB_SFP_STATUS0):
            rb_data_o = {{PAD_W{1'b0}}, sfp0_status_i};
         SB_ADDRW'(RB_SFP_STATUS1):
            rb_data_o = {{PAD_W{1'b0}}, sfp1_status_i};
         default:
            rb_data_o = '0;                     // Unmapped reads as zero
      endcase
   end

   //------------------------------------------------------------------------
   // Read-to-clear
   //------------------------------------------------------------------------
   // Flags drop on the next edge, after the slave has latched the word
   assign sfp_clr_o[0] = rb_rd_stb_i && (rb_addr_i == SB_ADDRW'(RB_SFP_STATUS0));
   assign sfp_clr_o[1] = rb_rd_stb_i && (rb_addr_i == SB_ADDRW'(RB_SFP_STATUS1));

endmodule

`default_nettype wire

//--- design/settings_slave.sv
// Bus slave for the settings/readback window. A write becomes one settings strobe,
// a read becomes one readback cycle, each followed by a single ack
`timescale 1ns/1ns
`default_nettype none

module settings_slave #(
   parameter int SB_ADDRW = 8
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        win_stb_i,
   input  logic                        bus_we_i,
   input  logic [zpu_ctrl_pkg::AW-1:0] bus_adr_i,
   input  logic [zpu_ctrl_pkg::DW-1:0] bus_dat_i,
   input  logic [zpu_ctrl_pkg::DW-1:0] rb_data_i,
   output logic                        win_ack_o,
   output logic [zpu_ctrl_pkg::DW-1:0] win_dat_o,
   output logic                        set_stb_o,
   output logic [SB_ADDRW-1:0]         set_addr_o,
   output logic [zpu_ctrl_pkg::DW-1:0] set_data_o,
   output logic                        rb_rd_stb_o,
   output logic [SB_ADDRW-1:0]         rb_addr_o
);

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_ISSUE = 2'd1;         // Strobe out, ack next
   localparam logic [1:0] S_ACK   = 2'd2;         // Wait for strobe to drop

   logic [1:0] state;

   //------------------------------------------------------------------------
   // Control FSM
   //------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= S_IDLE;
         set_stb_o   <= 1'b0;
         rb_rd_stb_o <= 1'b0;
         win_ack_o   <= 1'b0;
      end else begin
         set_stb_o   <= 1'b0;                     // Single-cycle pulses
         rb_rd_stb_o <= 1'b0;
         win_ack_o   <= 1'b0;
         case (state)
            S_IDLE: if (win_stb_i) begin
               set_stb_o   <= bus_we_i;
               rb_rd_stb_o <= ~bus_we_i;
               state       <= S_ISSUE;
            end
            S_ISSUE: begin
               win_ack_o <= 1'b1;
               state     <= S_ACK;
            end
            default: if (!win_stb_i)
               state <= S_IDLE;
         endcase
      end
   end

   //------------------------------------------------------------------------
   // Address and data capture
   //------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (state == S_IDLE && win_stb_i) begin
         set_addr_o <= bus_adr_i[SB_ADDRW+1:2];   // Word address
         rb_addr_o  <= bus_adr_i[SB_ADDRW+1:2];
         set_data_o <= bus_dat_i;
      end
      if (state == S_ISSUE)
         win_dat_o <= rb_rd_stb_o ? rb_data_i : '0;   // Writes return zero
   end

   a_set_stb_single: assert property (
      @(posedge clk) disable iff (rst) set_stb_o |=> !set_stb_o
   );

endmodule

`default_nettype wire

//--- design/sfp_monitor.sv
// SFP status pin monitor: two-stage synchronizer plus sticky change flags
// Flags hold until clr_i, which wins over a change in the same cycle
`timescale 1ns/1ns
`default_nettype none

module sfp_monitor (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [zpu_ctrl_pkg::SFP_PINS-1:0]   pins_i,    // {ModAbs, TxFault, RxLOS}
   input  logic                                clr_i,     // Status word was read
   output logic [2*zpu_ctrl_pkg::SFP_PINS-1:0] status_o   // {changed, levels}
);
   import zpu_ctrl_pkg::*;

   logic [SFP_PINS-1:0] sync1;                  // First stage, may be metastable
   logic [SFP_PINS-1:0] sync2;                  // Clean level
   logic [SFP_PINS-1:0] chgd;

   //------------------------------------------------------------------------
   // Synchronizer
   //------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         sync1 <= '0;
         sync2 <= '0;
      end else begin
         sync1 <= pins_i;
         sync2 <= sync1;
      end
   end

   //------------------------------------------------------------------------
   // Sticky change flags
   //------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst)
         chgd <= '0;
      else if (clr_i)
         chgd <= '0;
      else
         chgd <= chgd | (sync1 ^ sync2);        // Stages differ, edge in flight
   end

   assign status_o = {chgd, sync2};

endmodule

`default_nettype wire

//--- design/sys_bus_decode.sv
// Address decode for the processor bus. Routes the 0xA000 window to the settings
// slave and answers every other region itself with zero data
`timescale 1ns/1ns
`default_nettype none

module sys_bus_decode (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        bus_stb_i,
   input  logic [zpu_ctrl_pkg::AW-1:0] bus_adr_i,
   input  logic [zpu_ctrl_pkg::DW-1:0] win_dat_i,   // Window slave response
   input  logic                        win_ack_i,
   output logic                        win_stb_o,
   output logic [zpu_ctrl_pkg::DW-1:0] bus_dat_o,
   output logic                        bus_ack_o
);
   import zpu_ctrl_pkg::*;

   logic       win_hit;
   logic       empty_stb;
   logic [1:0] empty_tmr;                         // 0 idle, 1 wait, 2 ack, 3 done
   logic       empty_ack;

   // Region compare on the top nibble
   assign win_hit   = (bus_adr_i[AW-1 -: REGION_W] == SETTINGS_BASE);
   assign win_stb_o = bus_stb_i & win_hit;
   assign empty_stb = bus_stb_i & ~win_hit;

   //------------------------------------------------------------------------
   // Empty-region ack timer
   //------------------------------------------------------------------------
   // Counts up while the strobe is held, parks at 3 until the strobe drops
   always_ff @(posedge clk) begin
      if (rst) begin
         empty_tmr <= 2'd0;
      end else if (!empty_stb) begin
         empty_tmr <= 2'd0;                       // Strobe gone, rearm
      end else if (empty_tmr != 2'd3) begin
         empty_tmr <= empty_tmr + 2'd1;
      end
   end

   assign empty_ack = (empty_tmr == 2'd2);        // Same latency as the window

   // Merge responses, data only valid with the window ack
   assign bus_ack_o = win_ack_i | empty_ack;
   assign bus_dat_o = win_ack_i ? win_dat_i : '0;

   // No ack may be issued to a master that is not strobing
   a_ack_needs_stb: assert property (
      @(posedge clk) disable iff (rst) bus_ack_o |-> bus_stb_i
   );

endmodule

`default_nettype wire

//--- design/zpu_ctrl_pkg.sv
// Shared widths, address map and register numbers for the control-plane subsystem
// Imported by the RTL and the testbench
`default_nettype none

package zpu_ctrl_pkg;

   //------------------------------------------------------------------------
   // Processor bus
   //------------------------------------------------------------------------
   localparam int DW = 32;                       // Data width
   localparam int AW = 16;                       // Byte address width

   // Region select lives in the top address nibble
   localparam int         REGION_W      = 4;
   localparam logic [3:0] SETTINGS_BASE = 4'hA;  // 0xA000 settings/readback window

   //------------------------------------------------------------------------
   // Settings bus registers, word address inside the window
   //------------------------------------------------------------------------
   localparam int SR_SW_RST    = 0;              // Software reset bits
   localparam int SR_BOOT_DONE = 1;              // Firmware boot complete
   localparam int SR_LEDS      = 2;
   localparam int SR_SFP_CTRL0 = 3;              // RS0/RS1 drive-low enables
   localparam int SR_SFP_CTRL1 = 4;

   //------------------------------------------------------------------------
   // Readback addresses, same address bits
   //------------------------------------------------------------------------
   localparam int RB_COMPAT      = 0;
   localparam int RB_COUNTER     = 1;            // Free-running cycle count
   localparam int RB_SFP_STATUS0 = 2;            // {flags, levels} of port 0
   localparam int RB_SFP_STATUS1 = 3;

   // Compatibility word is {PRODUCT_ID, COMPAT_MAJOR, COMPAT_MINOR}
   localparam logic [7:0]  PRODUCT_ID   = 8'h02;
   localparam logic [15:0] COMPAT_MAJOR = 16'h0001;
   localparam logic [7:0]  COMPAT_MINOR = 8'h03;

   //------------------------------------------------------------------------
   // Field widths
   //------------------------------------------------------------------------
   localparam int SW_RST_W = 4;
   localparam int LEDS_W   = 16;
   localparam int SFP_PINS = 3;                  // ModAbs, TxFault, RxLOS

endpackage

`default_nettype wire

//--- design/zpu_ctrl_subsystem.sv
// Control-plane top: bus decode, settings slave, control registers, SFP monitors
// and readback mux. The external master performs single strobed reads and writes
`timescale 1ns/1ns
`default_nettype none

module zpu_ctrl_subsystem #(
   parameter int SB_ADDRW = 8                        // Settings/readback address width
) (
   input  logic                                clk,
   input  logic                                rst,
   // Processor data bus
   input  logic                                bus_stb_i,
   input  logic                                bus_we_i,
   input  logic [zpu_ctrl_pkg::AW-1:0]         bus_adr_i,
   input  logic [zpu_ctrl_pkg::DW-1:0]         bus_dat_i,
   output logic [zpu_ctrl_pkg::DW-1:0]         bus_dat_o,
   output logic                                bus_ack_o,
   // SFP pins, {ModAbs, TxFault, RxLOS}
   input  logic [zpu_ctrl_pkg::SFP_PINS-1:0]   sfp0_pins_i,
   input  logic [zpu_ctrl_pkg::SFP_PINS-1:0]   sfp1_pins_i,
   output logic [1:0]                          sfp0_rs_drv_o,  // High pulls RS low
   output logic [1:0]                          sfp1_rs_drv_o,
   // Misc control
   output logic [zpu_ctrl_pkg::SW_RST_W-1:0]   sw_rst_o,
   output logic [zpu_ctrl_pkg::LEDS_W-1:0]     leds_o,
   output logic                                cpu_rst_o
);
   import zpu_ctrl_pkg::*;

   //------------------------------------------------------------------------
   // Internal nets
   //------------------------------------------------------------------------
   logic                  win_stb;
   logic                  win_ack;
   logic [DW-1:0]         win_dat;

   logic                  set_stb;                  // Settings bus
   logic [SB_ADDRW-1:0]   set_addr;
   logic [DW-1:0]         set_data;

   logic                  rb_rd_stb;                // Readback
   logic [SB_ADDRW-1:0]   rb_addr;
   logic [DW-1:0]         rb_data;

   logic [2*SFP_PINS-1:0] sfp0_status;
   logic [2*SFP_PINS-1:0] sfp1_status;
   logic [1:0]            sfp_clr;                  // One per monitor

   //------------------------------------------------------------------------
   // Bus side
   //------------------------------------------------------------------------
   sys_bus_decode u_sys_bus_decode (
      .clk(clk), .rst(rst),
      .bus_stb_i(bus_stb_i), .bus_adr_i(bus_adr_i),
      .win_dat_i(win_dat), .win_ack_i(win_ack), .win_stb_o(win_stb),
      .bus_dat_o(bus_dat_o), .bus_ack_o(bus_ack_o)
   );

   settings_slave #(.SB_ADDRW(SB_ADDRW)) u_settings_slave (
      .clk(clk), .rst(rst),
      .win_stb_i(win_stb), .bus_we_i(bus_we_i),
      .bus_adr_i(bus_adr_i), .bus_dat_i(bus_dat_i),
      .rb_data_i(rb_data),
      .win_ack_o(win_ack), .win_dat_o(win_dat),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .rb_rd_stb_o(rb_rd_stb), .rb_addr_o(rb_addr)
   );

   //------------------------------------------------------------------------
   // Registers, SFP monitors, readback
   //------------------------------------------------------------------------
   ctrl_regs #(.SB_ADDRW(SB_ADDRW)) u_ctrl_regs (
      .clk(clk), .rst(rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .sw_rst_o(sw_rst_o), .leds_o(leds_o),
      .sfp0_rs_drv_o(sfp0_rs_drv_o), .sfp1_rs_drv_o(sfp1_rs_drv_o),
      .cpu_rst_o(cpu_rst_o)
   );

   sfp_monitor u_sfp_mon0 (
      .clk(clk), .rst(rst),
      .pins_i(sfp0_pins_i), .clr_i(sfp_clr[0]), .status_o(sfp0_status)
   );

   sfp_monitor u_sfp_mon1 (
      .clk(clk), .rst(rst),
      .pins_i(sfp1_pins_i), .clr_i(sfp_clr[1]), .status_o(sfp1_status)
   );

   readback_mux #(.SB_ADDRW(SB_ADDRW)) u_readback_mux (
      .clk(clk), .rst(rst),
      .rb_addr_i(rb_addr), .rb_rd_stb_i(rb_rd_stb),
      .sfp0_status_i(sfp0_status), .sfp1_status_i(sfp1_status),
      .rb_data_o(rb_data), .sfp_clr_o(sfp_clr)
   );

endmodule

`default_nettype wire
